// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    localparam int word_bits     = 32;
    localparam int reg_addr_bits = 5;

    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lbu = 4'd1,
        op_lh  = 4'd2,
        op_lhu = 4'd3,
        op_lw  = 4'd4,
        op_lwl = 4'd5,
        op_lwr = 4'd6,
        op_sb  = 4'd7,
        op_sh  = 4'd8,
        op_sw  = 4'd9
    } mem_op_t;     // codes 10..15 decode as no-op

    // one-hot kind vector, load bits keep the classic positions
    typedef logic [11:0] mem_inst_t;

    localparam int mi_lw  = 0;
    localparam int mi_sw  = 1;
    localparam int mi_lb  = 2;
    localparam int mi_lbu = 3;
    localparam int mi_lh  = 4;
    localparam int mi_lhu = 5;
    localparam int mi_lwl = 6;
    localparam int mi_lwr = 7;
    localparam int mi_sb  = 8;
    localparam int mi_sh  = 9;     // bits 10 and 11 spare

    typedef struct packed {
        logic [word_bits-1:0]     pc_tag;
        logic [word_bits-1:0]     addr;
        logic [word_bits-1:0]     rt_value;
        mem_inst_t                mem_inst;
        logic                     res_from_mem;
        logic                     gr_we;
        logic [reg_addr_bits-1:0] dest;
        logic                     ex;
        logic                     store_flow;
    } dec_payload_t;

    typedef struct packed {
        logic [word_bits-1:0]     pc_tag;
        logic [word_bits-1:0]     addr;
        logic [word_bits-1:0]     rt_value;
        mem_inst_t                mem_inst;
        logic                     res_from_mem;
        logic                     gr_we;
        logic [reg_addr_bits-1:0] dest;
        logic                     ex;
        logic                     store_flow;
    } res_payload_t;

endpackage

// ==== source/mem_op_decode.sv ====
module mem_op_decode
    import lsu_pkg::*;
(
    input  mem_op_t                  op,
    input  logic [word_bits-1:0]     addr,
    input  logic [word_bits-1:0]     rt_value,
    input  logic [reg_addr_bits-1:0] dest,
    input  logic [word_bits-1:0]     tag,
    output dec_payload_t             payload
);

    mem_inst_t kind;
    logic      is_load;
    logic      is_store;
    logic      half_acc;
    logic      word_acc;
    logic      misaligned;

    always_comb begin
        kind = '0;
        case (op)
            op_lb:   kind[mi_lb]  = 1'b1;
            op_lbu:  kind[mi_lbu] = 1'b1;
            op_lh:   kind[mi_lh]  = 1'b1;
            op_lhu:  kind[mi_lhu] = 1'b1;
            op_lw:   kind[mi_lw]  = 1'b1;
            op_lwl:  kind[mi_lwl] = 1'b1;
            op_lwr:  kind[mi_lwr] = 1'b1;
            op_sb:   kind[mi_sb]  = 1'b1;
            op_sh:   kind[mi_sh]  = 1'b1;
            op_sw:   kind[mi_sw]  = 1'b1;
            default: kind = '0;     // no-op, flows through without a write
        endcase
    end

    assign is_load  = kind[mi_lw] | kind[mi_lb] | kind[mi_lbu] | kind[mi_lh]
                    | kind[mi_lhu] | kind[mi_lwl] | kind[mi_lwr];
    assign is_store = kind[mi_sb] | kind[mi_sh] | kind[mi_sw];

    assign half_acc = kind[mi_lh] | kind[mi_lhu] | kind[mi_sh];
    assign word_acc = kind[mi_lw] | kind[mi_sw];

    // lwl/lwr take any offset
    assign misaligned = (half_acc & addr[0]) | (word_acc & (addr[1:0] != 2'b00));

    always_comb begin
        payload.pc_tag       = tag;
        payload.addr         = addr;
        payload.rt_value     = rt_value;
        payload.mem_inst     = kind;
        payload.res_from_mem = is_load;
        payload.gr_we        = is_load & ~misaligned;
        payload.dest         = dest;
        payload.ex           = misaligned;
        payload.store_flow   = is_store | misaligned;   // no wait on ram data
    end

endmodule

// ==== source/pipe_stage_reg.sv ====
module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     out_allowin,
    input  logic     ready_go,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_payload
);

    // empty, or the held item leaves this cycle
    assign allowin = !out_valid || (ready_go && out_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (allowin) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_payload <= '0;
        end else if (in_valid && allowin) begin
            out_payload <= in_payload;     // load only on transfer
        end
    end

endmodule

// ==== source/mem_access_unit.sv ====
module mem_access_unit
    import lsu_pkg::*;
(
    input  logic                 valid,
    input  dec_payload_t         payload,
    input  logic                 next_allowin,
    input  logic                 ram_busy,
    output logic                 ready_go,
    output logic                 ram_en,
    output logic [3:0]           ram_we,
    output logic [word_bits-3:0] ram_addr,
    output logic [word_bits-1:0] ram_wdata,
    output res_payload_t         res_payload
);

    logic                 is_store;
    logic                 access;
    logic                 issue;
    logic [1:0]           lane;
    logic [3:0]           byte_en;
    logic [word_bits-1:0] store_data;

    assign lane     = payload.addr[1:0];
    assign is_store = payload.mem_inst[mi_sb] | payload.mem_inst[mi_sh]
                    | payload.mem_inst[mi_sw];

    // a load waits while a slow read ahead of it is still pending
    assign ready_go = !(ram_busy && payload.res_from_mem);

    assign access = (payload.res_from_mem | is_store) & ~payload.ex;
    assign issue  = valid & ready_go & next_allowin & access;   // once, on transfer

    always_comb begin
        if (payload.mem_inst[mi_sb]) begin
            byte_en    = 4'b0001 << lane;
            store_data = {4{payload.rt_value[7:0]}};
        end else if (payload.mem_inst[mi_sh]) begin
            byte_en    = lane[1] ? 4'b1100 : 4'b0011;
            store_data = {2{payload.rt_value[15:0]}};
        end else begin
            byte_en    = 4'b1111;
            store_data = payload.rt_value;
        end
    end

    assign ram_en    = issue;
    assign ram_we    = (issue && is_store) ? byte_en : 4'b0000;
    assign ram_addr  = payload.addr[word_bits-1:2];     // word index
    assign ram_wdata = store_data;

    // an excepted item carries no memory kind into the result stage
    always_comb begin
        res_payload.pc_tag       = payload.pc_tag;
        res_payload.addr         = payload.addr;
        res_payload.rt_value     = payload.rt_value;
        res_payload.mem_inst     = payload.ex ? '0 : payload.mem_inst;
        res_payload.res_from_mem = payload.res_from_mem & ~payload.ex;
        res_payload.gr_we        = payload.gr_we;
        res_payload.dest         = payload.dest;
        res_payload.ex           = payload.ex;
        res_payload.store_flow   = payload.store_flow;
    end

endmodule

// ==== source/data_ram.sv ====
module data_ram
    import lsu_pkg::*;
#(
    parameter int ram_words = 256,
    parameter int slow_base = 192,
    parameter int read_wait = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 en,
    input  logic [3:0]           we,
    input  logic [word_bits-3:0] addr,
    input  logic [word_bits-1:0] wdata,
    output logic [word_bits-1:0] rdata,
    output logic                 busy
);

    localparam int idx_bits = (ram_words > 1) ? $clog2(ram_words) : 1;
    localparam int cnt_bits = (read_wait > 0) ? $clog2(read_wait + 1) : 1;

    logic [word_bits-1:0] mem [ram_words];
    logic [idx_bits-1:0]  idx;
    logic [idx_bits-1:0]  pend_idx;
    logic [cnt_bits-1:0]  wait_cnt;
    logic                 rd;
    logic                 slow;

    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    assign idx  = addr[idx_bits-1:0];
    assign rd   = en && (we == 4'b0000);
    assign slow = (read_wait > 0) && (int'(idx) >= slow_base);
    assign busy = (wait_cnt != '0);

    always @(posedge clk) begin
        if (en && we != 4'b0000) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (rd && !slow) begin
            rdata <= mem[idx];
        end else if (wait_cnt == cnt_bits'(1)) begin
            rdata <= mem[pend_idx];     // slow data lands as busy drops
        end
        if (rd) begin
            pend_idx <= idx;
        end
    end

    // busy for read_wait cycles after a slow read
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (rd && slow) begin
            wait_cnt <= cnt_bits'(read_wait);
        end else if (busy) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

// ==== source/load_align_result.sv ====
module load_align_result
    import lsu_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  res_payload_t             payload,
    input  logic [word_bits-1:0]     ram_rdata,
    input  logic                     ram_busy,
    input  logic                     wb_allowin,
    output logic                     ready_go,
    output logic                     wb_valid,
    output logic                     wb_ex,
    output logic                     wb_we,
    output logic [reg_addr_bits-1:0] wb_dest,
    output logic [word_bits-1:0]     wb_data,
    output logic [word_bits-1:0]     wb_tag,
    output logic [reg_addr_bits-1:0] fwd_dest,
    output logic [word_bits-1:0]     fwd_data
);

    logic                 have_data;
    logic [word_bits-1:0] rdata_r;
    logic [word_bits-1:0] rdata;
    logic [word_bits-1:0] rt;
    logic [1:0]           off;
    logic [7:0]           lb_byte;
    logic [15:0]          lh_half;
    logic [word_bits-1:0] lwl_res;
    logic [word_bits-1:0] lwr_res;
    logic [word_bits-1:0] mem_data;
    logic [word_bits-1:0] final_result;

    assign ready_go = payload.store_flow | ~ram_busy;
    assign wb_valid = valid & ready_go;

    // hold the read word once it arrives, the ram port may move on
    always_ff @(posedge clk) begin
        if (reset) begin
            have_data <= 1'b0;
        end else if (wb_valid && wb_allowin) begin
            have_data <= 1'b0;
        end else if (valid && !ram_busy) begin
            have_data <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !ram_busy && !have_data) begin
            rdata_r <= ram_rdata;
        end
    end

    assign rdata = have_data ? rdata_r : ram_rdata;
    assign rt    = payload.rt_value;
    assign off   = payload.addr[1:0];

    always_comb begin
        case (off)
            2'd0: begin
                lb_byte = rdata[7:0];
                lwl_res = {rdata[7:0], rt[23:0]};
                lwr_res = rdata;
            end
            2'd1: begin
                lb_byte = rdata[15:8];
                lwl_res = {rdata[15:0], rt[15:0]};
                lwr_res = {rt[31:24], rdata[31:8]};
            end
            2'd2: begin
                lb_byte = rdata[23:16];
                lwl_res = {rdata[23:0], rt[7:0]};
                lwr_res = {rt[31:16], rdata[31:16]};
            end
            default: begin
                lb_byte = rdata[31:24];
                lwl_res = rdata;
                lwr_res = {rt[31:8], rdata[31:24]};
            end
        endcase
    end

    assign lh_half = off[1] ? rdata[31:16] : rdata[15:0];     // odd offsets never get here

    always_comb begin
        if (payload.mem_inst[mi_lb]) begin
            mem_data = {{24{lb_byte[7]}}, lb_byte};
        end else if (payload.mem_inst[mi_lbu]) begin
            mem_data = {24'd0, lb_byte};
        end else if (payload.mem_inst[mi_lh]) begin
            mem_data = {{16{lh_half[15]}}, lh_half};
        end else if (payload.mem_inst[mi_lhu]) begin
            mem_data = {16'd0, lh_half};
        end else if (payload.mem_inst[mi_lwl]) begin
            mem_data = lwl_res;
        end else if (payload.mem_inst[mi_lwr]) begin
            mem_data = lwr_res;
        end else begin
            mem_data = rdata;     // lw
        end
    end

    assign final_result = payload.res_from_mem ? mem_data : payload.addr;

    assign wb_ex    = payload.ex;
    assign wb_we    = payload.gr_we & wb_valid;
    assign wb_dest  = payload.dest;
    assign wb_data  = final_result;
    assign wb_tag   = payload.pc_tag;
    assign fwd_dest = payload.dest & {reg_addr_bits{wb_valid}};     // zero when idle
    assign fwd_data = final_result;

endmodule

// ==== source/lsu_top.sv ====
module lsu_top
    import lsu_pkg::*;
#(
    parameter int ram_words = 256,
    parameter int slow_base = 192,
    parameter int read_wait = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  mem_op_t                  req_op,
    input  logic [word_bits-1:0]     req_addr,
    input  logic [word_bits-1:0]     req_rt_value,
    input  logic [reg_addr_bits-1:0] req_dest,
    input  logic [word_bits-1:0]     req_tag,
    output logic                     req_allowin,
    output logic                     wb_valid,
    output logic                     wb_ex,
    output logic                     wb_we,
    output logic [reg_addr_bits-1:0] wb_dest,
    output logic [word_bits-1:0]     wb_data,
    output logic [word_bits-1:0]     wb_tag,
    input  logic                     wb_allowin,
    output logic [reg_addr_bits-1:0] fwd_dest,
    output logic [word_bits-1:0]     fwd_data
);

    dec_payload_t         dec_payload;
    dec_payload_t         exe_payload;
    logic                 exe_valid;
    logic                 exe_ready_go;
    logic                 exe_to_res_valid;
    res_payload_t         res_in_payload;
    res_payload_t         res_payload;
    logic                 res_valid;
    logic                 res_allowin;
    logic                 res_ready_go;
    logic                 ram_en;
    logic [3:0]           ram_we;
    logic [word_bits-3:0] ram_addr;
    logic [word_bits-1:0] ram_wdata;
    logic [word_bits-1:0] ram_rdata;
    logic                 ram_busy;

    mem_op_decode decode_i (
        .op       (req_op),
        .addr     (req_addr),
        .rt_value (req_rt_value),
        .dest     (req_dest),
        .tag      (req_tag),
        .payload  (dec_payload)
    );

    pipe_stage_reg #(.payload_t(dec_payload_t)) exe_reg_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (req_valid),
        .in_payload  (dec_payload),
        .out_allowin (res_allowin),
        .ready_go    (exe_ready_go),
        .allowin     (req_allowin),
        .out_valid   (exe_valid),
        .out_payload (exe_payload)
    );

    mem_access_unit access_i (
        .valid        (exe_valid),
        .payload      (exe_payload),
        .next_allowin (res_allowin),
        .ram_busy     (ram_busy),
        .ready_go     (exe_ready_go),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .res_payload  (res_in_payload)
    );

    assign exe_to_res_valid = exe_valid & exe_ready_go;

    data_ram #(
        .ram_words (ram_words),
        .slow_base (slow_base),
        .read_wait (read_wait)
    ) ram_i (
        .clk   (clk),
        .reset (reset),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata),
        .busy  (ram_busy)
    );

    pipe_stage_reg #(.payload_t(res_payload_t)) res_reg_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (exe_to_res_valid),
        .in_payload  (res_in_payload),
        .out_allowin (wb_allowin),
        .ready_go    (res_ready_go),
        .allowin     (res_allowin),
        .out_valid   (res_valid),
        .out_payload (res_payload)
    );

    load_align_result result_i (
        .clk        (clk),
        .reset      (reset),
        .valid      (res_valid),
        .payload    (res_payload),
        .ram_rdata  (ram_rdata),
        .ram_busy   (ram_busy),
        .wb_allowin (wb_allowin),
        .ready_go   (res_ready_go),
        .wb_valid   (wb_valid),
        .wb_ex      (wb_ex),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data),
        .wb_tag     (wb_tag),
        .fwd_dest   (fwd_dest),
        .fwd_data   (fwd_data)
    );

endmodule

// ==== tb/lsu_assertions.sv ====
module lsu_assertions (
    input logic       clk,
    input logic       reset,
    input logic       req_valid,
    input logic       req_allowin,
    input logic       wb_valid,
    input logic       wb_allowin,
    input logic       wb_ex,
    input logic       wb_we,
    input logic [4:0] wb_dest,
    input logic [31:0] wb_data,
    input logic [31:0] wb_tag,
    input logic [4:0] fwd_dest,
    input logic [31:0] fwd_data,
    input logic       ram_en,
    input logic [3:0] ram_we
);
    timeunit 1ns;
    timeprecision 1ps;

    logic seen_req;
    int   fail_count = 0;     // failed assertions so far

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_req <= 1'b0;
        end else if (req_valid && req_allowin) begin
            seen_req <= 1'b1;
        end
    end

    // quiet pipeline until the first request is taken
    idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !seen_req |-> !wb_valid && fwd_dest == 5'd0 && !ram_en && ram_we == 4'b0000
                      && req_allowin)
    else begin
        fail_count++;
        $error("pipeline not idle after reset");
    end

    ex_blocks_we: assert property (@(posedge clk) disable iff (reset)
        wb_valid && wb_ex |-> !wb_we)
    else begin
        fail_count++;
        $error("excepted beat with register write");
    end

    hold_stable: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_allowin |=> wb_valid && $stable(wb_tag) && $stable(wb_data)
                                   && $stable(wb_dest) && $stable(wb_ex) && $stable(wb_we))
    else begin
        fail_count++;
        $error("write-back changed while stalled");
    end

    fwd_dest_match: assert property (@(posedge clk) disable iff (reset)
        fwd_dest == (wb_valid ? wb_dest : 5'd0))
    else begin
        fail_count++;
        $error("forwarding dest mismatch");
    end

    fwd_data_match: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> fwd_data == wb_data)
    else begin
        fail_count++;
        $error("forwarding data mismatch");
    end

endmodule

// ==== tb/lsu_tb.sv ====
module lsu_tb
    import lsu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ram_words = 256;
    localparam int slow_base = 192;
    localparam int read_wait = 2;

    // request counts per test, used for the timeout
    localparam int std_reqs      = 2 * 16;
    localparam int lwlr_reqs     = 9;
    localparam int misal_reqs    = 7;
    localparam int rand_reqs     = 40;
    localparam int num_requests  = std_reqs + lwlr_reqs + misal_reqs + rand_reqs;
    localparam int timeout_limit = num_requests * (3 + read_wait) * 4 + 200;

    typedef struct packed {
        logic [31:0] tag;
        logic        ex;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
    } beat_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        req_valid;
    mem_op_t     req_op;
    logic [31:0] req_addr;
    logic [31:0] req_rt_value;
    logic [4:0]  req_dest;
    logic [31:0] req_tag;
    logic        req_allowin;
    logic        wb_valid;
    logic        wb_ex;
    logic        wb_we;
    logic [4:0]  wb_dest;
    logic [31:0] wb_data;
    logic [31:0] wb_tag;
    logic        wb_allowin;
    logic [4:0]  fwd_dest;
    logic [31:0] fwd_data;

    integer      seed;
    logic [31:0] bp_draw;
    logic        bp_on;
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] tag_seq = 0;
    logic [31:0] shadow [ram_words];
    beat_t       exp_q[$];
    string       name_q[$];

    lsu_top #(
        .ram_words (ram_words),
        .slow_base (slow_base),
        .read_wait (read_wait)
    ) lsu_top_i (.*);

    bind lsu_top lsu_assertions lsu_assertions_i (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_allowin(req_allowin),
        .wb_valid(wb_valid), .wb_allowin(wb_allowin), .wb_ex(wb_ex), .wb_we(wb_we),
        .wb_dest(wb_dest), .wb_data(wb_data), .wb_tag(wb_tag), .fwd_dest(fwd_dest),
        .fwd_data(fwd_data), .ram_en(ram_en), .ram_we(ram_we)
    );

    always #10 clk = ~clk;

    function automatic logic misaligned(mem_op_t op, logic [1:0] off);
        case (op)
            op_lh, op_lhu, op_sh: return off[0];
            op_lw, op_sw:         return off != 2'b00;
            default:              return 1'b0;
        endcase
    endfunction

    // little-endian MIPS load rules, w is the addressed memory word
    function automatic logic [31:0] expected_load(mem_op_t op, logic [1:0] off,
                                                  logic [31:0] w, logic [31:0] rt);
        int          sh;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] keep;
        sh = 8 * int'(off);
        b  = w[sh +: 8];
        h  = w[16 * int'(off[1]) +: 16];
        case (op)
            op_lb:  return {{24{b[7]}}, b};
            op_lbu: return {24'd0, b};
            op_lh:  return {{16{h[15]}}, h};
            op_lhu: return {16'd0, h};
            op_lwl: begin
                keep = 32'hffff_ffff >> (sh + 8);     // rt bytes left below the loaded ones
                return (w << (24 - sh)) | (rt & keep);
            end
            op_lwr: begin
                keep = ~(32'hffff_ffff >> sh);
                return (w >> sh) | (rt & keep);
            end
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(mem_op_t op, logic [1:0] off,
                                                logic [31:0] w, logic [31:0] rt);
        logic [31:0] r;
        r = w;
        case (op)
            op_sb:   r[8 * int'(off) +: 8] = rt[7:0];
            op_sh:   r[16 * int'(off[1]) +: 16] = rt[15:0];
            op_sw:   r = rt;
            default: r = w;
        endcase
        return r;
    endfunction

    task automatic send_req(input mem_op_t op, input logic [31:0] addr,
                            input logic [31:0] rt, input logic [4:0] dest, input string name);
        beat_t beat;
        logic  is_load;
        logic  accepted;
        is_load   = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};
        beat.tag  = tag_seq;
        beat.ex   = misaligned(op, addr[1:0]);
        beat.we   = is_load && !beat.ex;
        beat.dest = dest;
        beat.data = beat.we ? expected_load(op, addr[1:0], shadow[addr[9:2]], rt) : addr;
        if (!is_load && !beat.ex) begin
            shadow[addr[9:2]] = merge_store(op, addr[1:0], shadow[addr[9:2]], rt);
        end
        exp_q.push_back(beat);
        name_q.push_back(name);
        req_valid    = 1'b1;
        req_op       = op;
        req_addr     = addr;
        req_rt_value = rt;
        req_dest     = dest;
        req_tag      = tag_seq;
        accepted     = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_allowin;     // transfer on the coming edge
            @(posedge clk);
            #2;
        end
        req_valid = 1'b0;
        tag_seq   = tag_seq + 1;
    endtask

    task automatic compare(input string name, input string field,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_beat();
        beat_t exp;
        string name;
        if (exp_q.size() == 0) begin
            $display("ERROR: write-back beat with tag %0d but no request outstanding", wb_tag);
            errors++;
        end else begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            compare(name, "tag", exp.tag, wb_tag);
            compare(name, "ex", 32'(exp.ex), 32'(wb_ex));
            compare(name, "we", 32'(exp.we), 32'(wb_we));
            compare(name, "dest", 32'(exp.dest), 32'(wb_dest));
            compare(name, "data", exp.data, wb_data);
        end
    endtask

    // a store, a byte and a half patch, then every legal load offset
    task automatic std_loads(input logic [31:0] base, input string tname);
        int i;
        send_req(op_sw, base, $random(seed), 5'd1, {tname, "_sw"});
        send_req(op_sb, base + 1, $random(seed), 5'd2, {tname, "_sb"});
        send_req(op_sh, base + 2, $random(seed), 5'd3, {tname, "_sh"});
        send_req(op_lw, base, 32'd0, 5'd4, {tname, "_lw"});
        for (i = 0; i < 4; i++) begin
            send_req(op_lb, base + i, 32'd0, 5'd5, $sformatf("%s_lb%0d", tname, i));
            send_req(op_lbu, base + i, 32'd0, 5'd6, $sformatf("%s_lbu%0d", tname, i));
        end
        for (i = 0; i < 4; i += 2) begin
            send_req(op_lh, base + i, 32'd0, 5'd7, $sformatf("%s_lh%0d", tname, i));
            send_req(op_lhu, base + i, 32'd0, 5'd8, $sformatf("%s_lhu%0d", tname, i));
        end
    endtask

    always begin
        @(posedge clk);
        #1;
        bp_draw = $random(seed);
        #1;
        wb_allowin = !(bp_on && bp_draw[1:0] == 2'b00);     // low about a quarter of the time
    end

    always @(negedge clk) begin
        if (!reset && wb_valid && wb_allowin) begin
            check_beat();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("ERROR: timeout after %0d cycles, %0d beats missing", cycles, exp_q.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        int          i;
        seed         = 41751;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = op_lw;
        req_addr     = 32'd0;
        req_rt_value = 32'd0;
        req_dest     = 5'd0;
        req_tag      = 32'd0;
        wb_allowin   = 1'b1;
        bp_on        = 1'b0;
        for (i = 0; i < ram_words; i++) begin
            shadow[i] = 32'd0;     // matches the zeroed ram
        end
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (3) @(posedge clk);     // idle window for the reset checks
        #2;

        std_loads(32'h0000_0014, "fast");
        std_loads(32'h0000_0320, "slow");     // word 200

        send_req(op_sw, 32'h24, $random(seed), 5'd9, "lwlr_sw");
        for (i = 0; i < 4; i++) begin
            send_req(op_lwl, 32'h24 + i, $random(seed), 5'd10, $sformatf("lwl%0d", i));
            send_req(op_lwr, 32'h24 + i, $random(seed), 5'd11, $sformatf("lwr%0d", i));
        end

        send_req(op_sw, 32'h30, 32'h8a5c_31e7, 5'd12, "misal_sw");
        send_req(op_lh, 32'h31, 32'd0, 5'd13, "misal_lh");
        send_req(op_lhu, 32'h33, 32'd0, 5'd14, "misal_lhu");
        send_req(op_lw, 32'h32, 32'd0, 5'd15, "misal_lw");
        send_req(op_sh, 32'h31, 32'hffff_ffff, 5'd16, "misal_sh");
        send_req(op_sw, 32'h33, 32'hffff_ffff, 5'd17, "misal_sw3");
        send_req(op_lw, 32'h30, 32'd0, 5'd18, "misal_check");

        bp_on = 1'b1;
        for (i = 0; i < rand_reqs; i++) begin
            rnd = $random(seed);
            send_req(mem_op_t'(4'(($unsigned($random(seed))) % 10)),
                     {22'd0, rnd[7:0], rnd[9:8]}, $random(seed), rnd[14:10],
                     $sformatf("rand%0d", i));
        end
        bp_on = 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);

        $display("errors: %0d scoreboard, %0d assertion", errors,
                 lsu_top_i.lsu_assertions_i.fail_count);
        if (errors == 0 && lsu_top_i.lsu_assertions_i.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== lsu_top.f ====
source/lsu_pkg.sv
source/mem_op_decode.sv
source/pipe_stage_reg.sv
source/mem_access_unit.sv
source/data_ram.sv
source/load_align_result.sv
source/lsu_top.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f lsu_top.f -o lsu_sim

status=0
./obj_dir/lsu_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    echo "result: failed"
    exit 1
fi
echo "result: passed"
